// File: verilog/mipsControlMacros_macros.svh
`ifndef MIPS_CONTROL_MACROS_SVH
`define MIPS_CONTROL_MACROS_SVH

// instruction field widths, standard MIPS32 layout
`define OP_W 6 // primary opcode, bits 31:26
`define REG_IDX_W 5 // rs and rt register indices
`define FUNCT_W 6 // func field of SPECIAL encodings, bits 5:0

// operation code handed to the ALU
`define ALUOP_W 5

// REGIMM puts the branch condition in rt
// rt of 1 is bgez, every other value falls to bltz
`define RT_BGEZ 5'd1

`endif

// File: verilog/mipsControlPkg.sv
`include "mipsControlMacros_macros.svh"

package mipsControlPkg;

	// primary opcodes, instr[31:26]
	typedef enum logic [`OP_W-1:0] {
		opSpecial = 6'b000000, // R-type, decoded by func
		opRegimm = 6'b000001, // bgez / bltz, picked by rt
		opJ = 6'b000010,
		opJal = 6'b000011,
		opBeq = 6'b000100,
		opBne = 6'b000101,
		opBlez = 6'b000110,
		opBgtz = 6'b000111,
		opAddiu = 6'b001001, // still overflow checked
		opSlti = 6'b001010,
		opSltiu = 6'b001011,
		opAndi = 6'b001100,
		opOri = 6'b001101,
		opXori = 6'b001110,
		opLui = 6'b001111,
		opLw = 6'b100011,
		opSw = 6'b101011
	} opcode_e;

	// func codes under opSpecial
	typedef enum logic [`FUNCT_W-1:0] {
		fnSll = 6'b000000,
		fnSrl = 6'b000010,
		fnSra = 6'b000011,
		fnSllv = 6'b000100,
		fnSrlv = 6'b000110,
		fnSrav = 6'b000111,
		fnJr = 6'b001000,
		fnJalr = 6'b001001,
		fnMfhi = 6'b010000,
		fnMthi = 6'b010001,
		fnMflo = 6'b010010,
		fnMtlo = 6'b010011,
		fnMult = 6'b011000,
		fnAdd = 6'b100000,
		fnAddu = 6'b100001,
		fnSub = 6'b100010,
		fnSubu = 6'b100011,
		fnAnd = 6'b100100,
		fnOr = 6'b100101,
		fnXor = 6'b100110,
		fnNor = 6'b100111,
		fnSlt = 6'b101010,
		fnSltu = 6'b101011
	} funct_e;

	// ALU operation codes, must match the ALU decode
	typedef enum logic [`ALUOP_W-1:0] {
		aluAddu = 5'd0,
		aluSubu = 5'd1,
		aluSlt = 5'd2,
		aluAnd = 5'd3,
		aluNor = 5'd4,
		aluOr = 5'd5,
		aluXor = 5'd6,
		aluSll = 5'd7,
		aluSrl = 5'd8,
		aluSltu = 5'd9,
		aluJalr = 5'd10, // passes pc + 8 through for the link
		aluJr = 5'd11,
		aluSllv = 5'd12,
		aluSra = 5'd13,
		aluSrav = 5'd14,
		aluSrlv = 5'd15,
		aluLui = 5'd16,
		aluMult = 5'd17
	} aluOp_e;

	// register file write-back source
	typedef enum logic [1:0] {
		wbAlu = 2'd0,
		wbMem = 2'd1,
		wbHiLo = 2'd2 // hlSel picks HI or LO
	} wbSel_e;

	typedef enum logic [2:0] {
		brNone = 3'd0,
		brBeq = 3'd1,
		brBne = 3'd2,
		brBgez = 3'd3,
		brBgtz = 3'd4,
		brBlez = 3'd5,
		brBltz = 3'd6
	} branchKind_e;

	typedef struct packed {
		logic [`OP_W-1:0] op;
		logic [`REG_IDX_W-1:0] rs;
		logic [`REG_IDX_W-1:0] rt;
		logic [`FUNCT_W-1:0] func;
	} instrFields_t;

	typedef struct packed {
		logic regWr;
		logic regDst; // 1 writes rd, 0 writes rt
		logic extOp; // sign extend the immediate
		logic aluSrc; // immediate as ALU operand b
		logic memWr;
		logic checkOver; // trap on signed overflow
		logic jump;
		logic jal;
		logic jalr; // register jump, jr and jalr
		logic r31Wr;
		logic multWr;
		logic hlSel; // 1 reads HI
		logic loIn;
		logic hiIn;
		wbSel_e wbSel;
		branchKind_e branch;
		aluOp_e aluOp;
	} ctrl_t;

endpackage

// File: verilog/functDecoder.sv
module functDecoder (
	input mipsControlPkg::funct_e funct,
	output mipsControlPkg::ctrl_t specialCtrl
);

	// func alone, opSpecial is checked one level up
	always_comb begin
		specialCtrl = '0; // unknown func stays all zero
		case (funct)
			mipsControlPkg::fnSll: begin
				specialCtrl.regDst = 1'b1;
				specialCtrl.regWr = 1'b1;
				specialCtrl.aluOp = mipsControlPkg::aluSll; // shamt shift
			end
			mipsControlPkg::fnSrl: begin
				specialCtrl.regDst = 1'b1;
				specialCtrl.regWr = 1'b1;
				specialCtrl.aluOp = mipsControlPkg::aluSrl;
			end
			mipsControlPkg::fnSra: begin
				specialCtrl.regDst = 1'b1;
				specialCtrl.regWr = 1'b1;
				specialCtrl.aluOp = mipsControlPkg::aluSra;
			end
			mipsControlPkg::fnSllv: begin
				specialCtrl.regDst = 1'b1;
				specialCtrl.regWr = 1'b1;
				specialCtrl.aluOp = mipsControlPkg::aluSllv; // amount from rs
			end
			mipsControlPkg::fnSrlv: begin
				specialCtrl.regDst = 1'b1;
				specialCtrl.regWr = 1'b1;
				specialCtrl.aluOp = mipsControlPkg::aluSrlv;
			end
			mipsControlPkg::fnSrav: begin
				specialCtrl.regDst = 1'b1;
				specialCtrl.regWr = 1'b1;
				specialCtrl.aluOp = mipsControlPkg::aluSrav;
			end
			mipsControlPkg::fnAdd: begin
				specialCtrl.regDst = 1'b1;
				specialCtrl.regWr = 1'b1;
				specialCtrl.checkOver = 1'b1;
				specialCtrl.aluOp = mipsControlPkg::aluAddu;
			end
			mipsControlPkg::fnAddu: begin
				specialCtrl.regDst = 1'b1;
				specialCtrl.regWr = 1'b1;
				specialCtrl.aluOp = mipsControlPkg::aluAddu;
			end
			mipsControlPkg::fnSub: begin
				specialCtrl.regDst = 1'b1;
				specialCtrl.regWr = 1'b1;
				specialCtrl.checkOver = 1'b1;
				specialCtrl.aluOp = mipsControlPkg::aluSubu;
			end
			mipsControlPkg::fnSubu: begin
				specialCtrl.regDst = 1'b1;
				specialCtrl.regWr = 1'b1;
				specialCtrl.aluOp = mipsControlPkg::aluSubu;
			end
			mipsControlPkg::fnAnd: begin
				specialCtrl.regDst = 1'b1;
				specialCtrl.regWr = 1'b1;
				specialCtrl.aluOp = mipsControlPkg::aluAnd;
			end
			mipsControlPkg::fnOr: begin
				specialCtrl.regDst = 1'b1;
				specialCtrl.regWr = 1'b1;
				specialCtrl.aluOp = mipsControlPkg::aluOr;
			end
			mipsControlPkg::fnXor: begin
				specialCtrl.regDst = 1'b1;
				specialCtrl.regWr = 1'b1;
				specialCtrl.aluOp = mipsControlPkg::aluXor;
			end
			mipsControlPkg::fnNor: begin
				specialCtrl.regDst = 1'b1;
				specialCtrl.regWr = 1'b1;
				specialCtrl.aluOp = mipsControlPkg::aluNor;
			end
			mipsControlPkg::fnSlt: begin
				specialCtrl.regDst = 1'b1;
				specialCtrl.regWr = 1'b1;
				specialCtrl.aluOp = mipsControlPkg::aluSlt;
			end
			mipsControlPkg::fnSltu: begin
				specialCtrl.regDst = 1'b1;
				specialCtrl.regWr = 1'b1;
				specialCtrl.aluOp = mipsControlPkg::aluSltu;
			end
			mipsControlPkg::fnJr: begin
				specialCtrl.jalr = 1'b1; // target from rs, no link
				specialCtrl.aluOp = mipsControlPkg::aluJr;
			end
			mipsControlPkg::fnJalr: begin
				specialCtrl.jalr = 1'b1;
				specialCtrl.r31Wr = 1'b1; // link into r31
				specialCtrl.aluOp = mipsControlPkg::aluJalr;
			end
			mipsControlPkg::fnMult: begin
				specialCtrl.multWr = 1'b1; // product to HI/LO
				specialCtrl.aluOp = mipsControlPkg::aluMult;
			end
			mipsControlPkg::fnMfhi: begin
				specialCtrl.regDst = 1'b1;
				specialCtrl.regWr = 1'b1;
				specialCtrl.wbSel = mipsControlPkg::wbHiLo;
				specialCtrl.hlSel = 1'b1; // read HI
			end
			mipsControlPkg::fnMflo: begin
				specialCtrl.regDst = 1'b1;
				specialCtrl.regWr = 1'b1;
				specialCtrl.wbSel = mipsControlPkg::wbHiLo; // hlSel low reads LO
			end
			mipsControlPkg::fnMthi: begin
				specialCtrl.hiIn = 1'b1; // rs into HI
			end
			mipsControlPkg::fnMtlo: begin
				specialCtrl.loIn = 1'b1; // rs into LO
			end
			default: begin
				specialCtrl = '0;
			end
		endcase
	end

endmodule

// File: verilog/opcodeDecoder.sv
`include "mipsControlMacros_macros.svh"

module opcodeDecoder (
	input mipsControlPkg::opcode_e op,
	input logic [`REG_IDX_W-1:0] rt,
	input mipsControlPkg::ctrl_t specialCtrl,
	output mipsControlPkg::ctrl_t ctrl
);

	always_comb begin
		ctrl = '0; // undefined opcodes give the zero word
		case (op)
			mipsControlPkg::opSpecial: begin
				ctrl = specialCtrl; // R-type word comes from func
			end

			// immediate ALU group
			mipsControlPkg::opAddiu: begin
				ctrl.regWr = 1'b1;
				ctrl.aluSrc = 1'b1;
				ctrl.extOp = 1'b1;
				ctrl.checkOver = 1'b1; // kept from the addi behavior
				ctrl.aluOp = mipsControlPkg::aluAddu;
			end
			mipsControlPkg::opSlti: begin
				ctrl.regWr = 1'b1;
				ctrl.aluSrc = 1'b1;
				ctrl.extOp = 1'b1;
				ctrl.aluOp = mipsControlPkg::aluSlt;
			end
			mipsControlPkg::opSltiu: begin
				ctrl.regWr = 1'b1;
				ctrl.aluSrc = 1'b1;
				ctrl.extOp = 1'b1; // sign extended, then compared unsigned
				ctrl.aluOp = mipsControlPkg::aluSltu;
			end
			mipsControlPkg::opAndi: begin
				ctrl.regWr = 1'b1;
				ctrl.aluSrc = 1'b1;
				ctrl.aluOp = mipsControlPkg::aluAnd; // zero extended
			end
			mipsControlPkg::opOri: begin
				ctrl.regWr = 1'b1;
				ctrl.aluSrc = 1'b1;
				ctrl.aluOp = mipsControlPkg::aluOr;
			end
			mipsControlPkg::opXori: begin
				ctrl.regWr = 1'b1;
				ctrl.aluSrc = 1'b1;
				ctrl.aluOp = mipsControlPkg::aluXor;
			end
			mipsControlPkg::opLui: begin
				ctrl.regWr = 1'b1;
				ctrl.aluSrc = 1'b1;
				ctrl.aluOp = mipsControlPkg::aluLui;
			end

			// loads and stores, address is rs + simm
			mipsControlPkg::opLw: begin
				ctrl.regWr = 1'b1;
				ctrl.aluSrc = 1'b1;
				ctrl.extOp = 1'b1;
				ctrl.wbSel = mipsControlPkg::wbMem;
				ctrl.aluOp = mipsControlPkg::aluAddu;
			end
			mipsControlPkg::opSw: begin
				ctrl.memWr = 1'b1;
				ctrl.aluSrc = 1'b1;
				ctrl.extOp = 1'b1;
				ctrl.aluOp = mipsControlPkg::aluAddu;
			end

			// conditional branches
			mipsControlPkg::opBeq: begin
				ctrl.branch = mipsControlPkg::brBeq;
				ctrl.aluOp = mipsControlPkg::aluSubu; // zero flag compare
			end
			mipsControlPkg::opBne: begin
				ctrl.branch = mipsControlPkg::brBne;
				ctrl.aluOp = mipsControlPkg::aluSubu;
			end
			mipsControlPkg::opBlez: begin
				ctrl.branch = mipsControlPkg::brBlez;
			end
			mipsControlPkg::opBgtz: begin
				ctrl.branch = mipsControlPkg::brBgtz;
			end
			mipsControlPkg::opRegimm: begin
				// rt selects the condition
				ctrl.branch = (rt == `RT_BGEZ) ? mipsControlPkg::brBgez
					: mipsControlPkg::brBltz;
			end

			// absolute jumps
			mipsControlPkg::opJ: begin
				ctrl.jump = 1'b1;
			end
			mipsControlPkg::opJal: begin
				ctrl.jump = 1'b1;
				ctrl.jal = 1'b1;
				ctrl.r31Wr = 1'b1; // return address to r31
				ctrl.aluOp = mipsControlPkg::aluJalr;
			end

			default: begin
				ctrl = '0;
			end
		endcase
	end

endmodule

// File: verilog/mipsControl.sv
module mipsControl (
	input mipsControlPkg::instrFields_t instr,
	output mipsControlPkg::ctrl_t ctrl
);

	mipsControlPkg::ctrl_t specialCtrl; // func decode, used for opSpecial only

	// rs is not needed by any decoded instruction
	functDecoder i_functDecoder (
		.funct(mipsControlPkg::funct_e'(instr.func)),
		.specialCtrl(specialCtrl)
	);

	opcodeDecoder i_opcodeDecoder (
		.op(mipsControlPkg::opcode_e'(instr.op)),
		.rt(instr.rt), // REGIMM condition
		.specialCtrl(specialCtrl),
		.ctrl(ctrl)
	);

endmodule

// File: dv/mipsControlTb.sv
`include "mipsControlMacros_macros.svh"

module mipsControlTb;

	logic clk = 1'b0;
	logic rstN;
	mipsControlPkg::instrFields_t instr;
	mipsControlPkg::ctrl_t ctrl;
	int errCount;
	int passCount;
	int failCount;

	mipsControl i_mipsControl (
		.instr(instr),
		.ctrl(ctrl)
	);

	always #5 clk = ~clk; // 10 unit period

	initial begin
		rstN <= 1'b0;
		repeat (8) @(posedge clk);
		rstN <= 1'b1;
	end

	task automatic checkBit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
			errCount++;
		end
	endtask

	task automatic checkAluOp(input mipsControlPkg::aluOp_e got,
			input mipsControlPkg::aluOp_e exp, input string ctx);
		if (got !== exp) begin
			$display("mismatch %s.aluOp: got 0x%0h, expected 0x%0h", ctx, got, exp);
			errCount++;
		end
	endtask

	task automatic checkBranch(input mipsControlPkg::branchKind_e got,
			input mipsControlPkg::branchKind_e exp, input string ctx);
		if (got !== exp) begin
			$display("mismatch %s.branch: got 0x%0h, expected 0x%0h", ctx, got, exp);
			errCount++;
		end
	endtask

	task automatic checkCtrl(input mipsControlPkg::ctrl_t got, input mipsControlPkg::ctrl_t exp,
			input string ctx);
		checkBit({ctx, ".regWr"}, got.regWr, exp.regWr);
		checkBit({ctx, ".regDst"}, got.regDst, exp.regDst);
		checkBit({ctx, ".extOp"}, got.extOp, exp.extOp);
		checkBit({ctx, ".aluSrc"}, got.aluSrc, exp.aluSrc);
		checkBit({ctx, ".memWr"}, got.memWr, exp.memWr);
		checkBit({ctx, ".checkOver"}, got.checkOver, exp.checkOver);
		checkBit({ctx, ".jump"}, got.jump, exp.jump);
		checkBit({ctx, ".jal"}, got.jal, exp.jal);
		checkBit({ctx, ".jalr"}, got.jalr, exp.jalr);
		checkBit({ctx, ".r31Wr"}, got.r31Wr, exp.r31Wr);
		checkBit({ctx, ".multWr"}, got.multWr, exp.multWr);
		checkBit({ctx, ".hlSel"}, got.hlSel, exp.hlSel);
		checkBit({ctx, ".loIn"}, got.loIn, exp.loIn);
		checkBit({ctx, ".hiIn"}, got.hiIn, exp.hiIn);
		if (got.wbSel !== exp.wbSel) begin
			$display("mismatch %s.wbSel: got 0x%0h, expected 0x%0h", ctx, got.wbSel, exp.wbSel);
			errCount++;
		end
		checkBranch(got.branch, exp.branch, ctx);
		checkAluOp(got.aluOp, exp.aluOp, ctx);
	endtask

	task automatic applyInstr(input logic [`OP_W-1:0] op, input logic [`REG_IDX_W-1:0] rs,
			input logic [`REG_IDX_W-1:0] rt, input logic [`FUNCT_W-1:0] func);
		@(posedge clk);
		instr <= '{op: op, rs: rs, rt: rt, func: func};
		@(negedge clk); // ctrl settled half a cycle later
	endtask

	// once with zero register fields, once with random ones
	task automatic applyAndCheck(input logic [`OP_W-1:0] op, input logic [`FUNCT_W-1:0] func,
			input mipsControlPkg::ctrl_t exp, input string ctx);
		applyInstr(op, '0, '0, func);
		checkCtrl(ctrl, exp, ctx);
		applyInstr(op, 5'($urandom), 5'($urandom), func);
		checkCtrl(ctrl, exp, {ctx, " random rs/rt"});
	endtask

	task automatic finishTest(input string name, input int errBefore);
		if (errCount == errBefore) begin
			passCount++;
			$display("test %s: ok", name);
		end else begin
			failCount++;
			$display("test %s: %0d errors", name, errCount - errBefore);
		end
	endtask

	// R-type ALU word: rd written from the ALU
	function automatic mipsControlPkg::ctrl_t regAluExp(input mipsControlPkg::aluOp_e aluOp,
			input logic over);
		mipsControlPkg::ctrl_t e;
		e = '0;
		e.regWr = 1'b1;
		e.regDst = 1'b1;
		e.wbSel = mipsControlPkg::wbAlu;
		e.checkOver = over;
		e.aluOp = aluOp;
		return e;
	endfunction

	task automatic testRtype();
		mipsControlPkg::funct_e fns[16] = '{
			mipsControlPkg::fnSll, mipsControlPkg::fnSrl, mipsControlPkg::fnSra,
			mipsControlPkg::fnSllv, mipsControlPkg::fnSrlv, mipsControlPkg::fnSrav,
			mipsControlPkg::fnAdd, mipsControlPkg::fnAddu, mipsControlPkg::fnSub,
			mipsControlPkg::fnSubu, mipsControlPkg::fnAnd, mipsControlPkg::fnOr,
			mipsControlPkg::fnXor, mipsControlPkg::fnNor, mipsControlPkg::fnSlt,
			mipsControlPkg::fnSltu};
		mipsControlPkg::aluOp_e alus[16] = '{
			mipsControlPkg::aluSll, mipsControlPkg::aluSrl, mipsControlPkg::aluSra,
			mipsControlPkg::aluSllv, mipsControlPkg::aluSrlv, mipsControlPkg::aluSrav,
			mipsControlPkg::aluAddu, mipsControlPkg::aluAddu, mipsControlPkg::aluSubu,
			mipsControlPkg::aluSubu, mipsControlPkg::aluAnd, mipsControlPkg::aluOr,
			mipsControlPkg::aluXor, mipsControlPkg::aluNor, mipsControlPkg::aluSlt,
			mipsControlPkg::aluSltu};
		logic over;
		int errBefore;
		errBefore = errCount;
		foreach (fns[i]) begin
			over = (fns[i] == mipsControlPkg::fnAdd) || (fns[i] == mipsControlPkg::fnSub);
			applyAndCheck(mipsControlPkg::opSpecial, fns[i], regAluExp(alus[i], over),
				fns[i].name());
		end
		finishTest("rtype", errBefore);
	endtask

	task automatic testImmMem();
		mipsControlPkg::opcode_e ops[7] = '{
			mipsControlPkg::opAddiu, mipsControlPkg::opSlti, mipsControlPkg::opSltiu,
			mipsControlPkg::opAndi, mipsControlPkg::opOri, mipsControlPkg::opXori,
			mipsControlPkg::opLui};
		mipsControlPkg::aluOp_e alus[7] = '{
			mipsControlPkg::aluAddu, mipsControlPkg::aluSlt, mipsControlPkg::aluSltu,
			mipsControlPkg::aluAnd, mipsControlPkg::aluOr, mipsControlPkg::aluXor,
			mipsControlPkg::aluLui};
		mipsControlPkg::ctrl_t e;
		int errBefore;
		errBefore = errCount;
		foreach (ops[i]) begin
			e = '0;
			e.regWr = 1'b1;
			e.aluSrc = 1'b1;
			e.extOp = (i < 3); // addiu, slti, sltiu sign extend
			e.checkOver = (ops[i] == mipsControlPkg::opAddiu);
			e.aluOp = alus[i];
			applyAndCheck(ops[i], '0, e, ops[i].name());
		end
		e = '0; // address is rs plus the sign extended offset
		e.regWr = 1'b1;
		e.aluSrc = 1'b1;
		e.extOp = 1'b1;
		e.wbSel = mipsControlPkg::wbMem;
		e.aluOp = mipsControlPkg::aluAddu;
		applyAndCheck(mipsControlPkg::opLw, '0, e, "lw");
		e.regWr = 1'b0;
		e.wbSel = mipsControlPkg::wbAlu;
		e.memWr = 1'b1;
		applyAndCheck(mipsControlPkg::opSw, '0, e, "sw");
		finishTest("immediate and memory", errBefore);
	endtask

	task automatic testBranch();
		mipsControlPkg::ctrl_t e;
		logic [`REG_IDX_W-1:0] rt;
		int errBefore;
		errBefore = errCount;
		e = '0;
		e.aluOp = mipsControlPkg::aluSubu; // equality through subtraction
		e.branch = mipsControlPkg::brBeq;
		applyAndCheck(mipsControlPkg::opBeq, '0, e, "beq");
		e.branch = mipsControlPkg::brBne;
		applyAndCheck(mipsControlPkg::opBne, '0, e, "bne");
		e = '0;
		e.branch = mipsControlPkg::brBgtz;
		applyAndCheck(mipsControlPkg::opBgtz, '0, e, "bgtz");
		e.branch = mipsControlPkg::brBlez;
		applyAndCheck(mipsControlPkg::opBlez, '0, e, "blez");
		e.branch = mipsControlPkg::brBgez;
		applyInstr(mipsControlPkg::opRegimm, 5'($urandom), 5'd1, '0);
		checkCtrl(ctrl, e, "bgez");
		e.branch = mipsControlPkg::brBltz;
		repeat (20) begin
			rt = 5'($urandom);
			if (rt == 5'd1) begin
				rt = 5'd0; // stay off the bgez value
			end
			applyInstr(mipsControlPkg::opRegimm, 5'($urandom), rt, '0);
			checkCtrl(ctrl, e, $sformatf("bltz rt=0x%0h", rt));
		end
		finishTest("branch", errBefore);
	endtask

	task automatic testJump();
		mipsControlPkg::ctrl_t e;
		int errBefore;
		errBefore = errCount;
		e = '0;
		e.jump = 1'b1;
		applyAndCheck(mipsControlPkg::opJ, '0, e, "j");
		e.jal = 1'b1;
		e.r31Wr = 1'b1;
		e.aluOp = mipsControlPkg::aluJalr; // link value from the ALU
		applyAndCheck(mipsControlPkg::opJal, '0, e, "jal");
		e = '0;
		e.jalr = 1'b1;
		e.aluOp = mipsControlPkg::aluJr;
		applyAndCheck(mipsControlPkg::opSpecial, mipsControlPkg::fnJr, e, "jr");
		e.r31Wr = 1'b1;
		e.aluOp = mipsControlPkg::aluJalr;
		applyAndCheck(mipsControlPkg::opSpecial, mipsControlPkg::fnJalr, e, "jalr");
		finishTest("jump", errBefore);
	endtask

	task automatic testHiLo();
		mipsControlPkg::ctrl_t e;
		int errBefore;
		errBefore = errCount;
		e = '0;
		e.multWr = 1'b1;
		e.aluOp = mipsControlPkg::aluMult;
		applyAndCheck(mipsControlPkg::opSpecial, mipsControlPkg::fnMult, e, "mult");
		e = '0;
		e.regWr = 1'b1;
		e.regDst = 1'b1;
		e.wbSel = mipsControlPkg::wbHiLo;
		e.hlSel = 1'b1;
		applyAndCheck(mipsControlPkg::opSpecial, mipsControlPkg::fnMfhi, e, "mfhi");
		e.hlSel = 1'b0;
		applyAndCheck(mipsControlPkg::opSpecial, mipsControlPkg::fnMflo, e, "mflo");
		e = '0;
		e.hiIn = 1'b1;
		applyAndCheck(mipsControlPkg::opSpecial, mipsControlPkg::fnMthi, e, "mthi");
		e = '0;
		e.loIn = 1'b1;
		applyAndCheck(mipsControlPkg::opSpecial, mipsControlPkg::fnMtlo, e, "mtlo");
		finishTest("hi/lo", errBefore);
	endtask

	task automatic testUndefined();
		int errBefore;
		errBefore = errCount;
		applyAndCheck(6'b111111, '0, '0, "op 0x3f");
		applyAndCheck(6'b100000, '0, '0, "op 0x20"); // lb, dropped
		applyAndCheck(6'b010000, '0, '0, "op 0x10"); // cop0, dropped
		applyAndCheck(mipsControlPkg::opSpecial, 6'b000001, '0, "func 0x01");
		applyAndCheck(mipsControlPkg::opSpecial, 6'b001100, '0, "func 0x0c"); // syscall
		applyAndCheck(mipsControlPkg::opSpecial, 6'b111111, '0, "func 0x3f");
		finishTest("undefined", errBefore);
	endtask

	initial begin
		int waitCycles;
		instr <= '0;
		errCount = 0;
		passCount = 0;
		failCount = 0;
		void'($urandom(32'hd8f0));
		waitCycles = 0;
		while (rstN !== 1'b1 && waitCycles < 50) begin
			@(posedge clk);
			waitCycles++;
		end
		if (rstN !== 1'b1) begin
			$display("timeout: reset still asserted after %0d cycles", waitCycles);
			failCount++;
		end else begin
			testRtype();
			testImmMem();
			testBranch();
			testJump();
			testHiLo();
			testUndefined();
		end
		$display("tests passed: %0d, failed: %0d", passCount, failCount);
		if (failCount == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

// File: mipsControl.f
+incdir+verilog
verilog/mipsControlPkg.sv
verilog/functDecoder.sv
verilog/opcodeDecoder.sv
verilog/mipsControl.sv
dv/mipsControlTb.sv

// File: runSim.sh
#!/bin/sh
# Build and run the mipsControl testbench with Verilator.
# Exit status is 0 only when the log holds the pass line.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

if ! command -v verilator >/dev/null 2>&1; then
	echo "verilator not found in PATH"
	exit 1
fi

verilator --binary --timing \
	-f mipsControl.f \
	--top-module mipsControlTb \
	--Mdir "$BUILD_DIR" \
	-o simv
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

"./$BUILD_DIR/simv" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "ALL TESTS PASSED" "$LOG"; then
	echo "result: pass"
	exit 0
else
	echo "result: fail, see $LOG"
	exit 1
fi
